//--- verilog/consul_pkg.sv
package consul_pkg;

    // Status relay lines, in machine line order
    typedef struct packed {
        logic       cin_ready;              // Key code present
        logic       top_symbol_correction;
        logic       red_print;
        logic       co_acq;                 // Print acknowledge
        logic       high_reg;               // Upper case active
        logic       is_moving;              // Carriage moving
        logic       block_print;
        logic       need_nl;                // End of line reached
        logic [7:0] key_code;               // Bit 7 is the strobe
    } consul_status_t;

    // Command relay lines
    typedef struct packed {
        logic       kb_block;
        logic       set_tab;
        logic       sync;
        logic [6:0] code;
    } consul_command_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_KEY,
        SET_CODE,
        SET_SYNC,
        WAIT_PRINT,
        WAIT_SHIFT
    } consul_state_e;

    typedef enum logic [1:0] {
        PK_CR,
        PK_SHIFT,
        PK_CHAR
    } print_kind_e;

    localparam logic [6:0] CODE_CR = 7'h0d;

    // Low bit of a shift code selects the case
    localparam logic [5:0] SHIFT_CODE_BASE = 6'b000111;

endpackage

//--- verilog/consul_line_interface.sv
module consul_line_interface (
    input  logic                      Clk,
    input  logic                      Rst_n,

    // Machine side
    input  consul_pkg::consul_status_t  status_lines,
    output consul_pkg::consul_command_t command_lines,

    // Controller side
    input  consul_pkg::consul_command_t command_next,
    output consul_pkg::consul_status_t  status,
    output logic                        key_valid
);

    logic key_strobe;
    logic key_parity;

    assign key_strobe = status_lines.key_code[7];
    assign key_parity = ^status_lines.key_code[6:0];   // Odd parity gives 1

    // Status lines into the clock domain, one cycle of latency
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            status    <= '0;
            key_valid <= 1'b0;
        end else begin
            status    <= status_lines;
            key_valid <= key_strobe & key_parity;
        end
    end

    // Command lines out to the relays
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            command_lines          <= '0;
            command_lines.kb_block <= 1'b1;    // Keyboard blocked after reset
        end else begin
            command_lines <= command_next;
        end
    end

endmodule

//--- verilog/consul_print_encoder.sv
module consul_print_encoder (
    input  logic [7:0]                 print_char,
    input  consul_pkg::consul_status_t status,
    output logic [6:0]                 next_code,
    output consul_pkg::print_kind_e    kind
);

    logic want_upper;
    logic case_wrong;

    assign want_upper = print_char[5];
    assign case_wrong = (status.high_reg == ~want_upper);

    // Carriage return wins over a case shift, a shift wins over the character
    always_comb begin
        if (status.need_nl) begin
            kind      = consul_pkg::PK_CR;
            next_code = consul_pkg::CODE_CR;
        end else if (case_wrong) begin
            kind      = consul_pkg::PK_SHIFT;
            next_code = {consul_pkg::SHIFT_CODE_BASE, want_upper};
        end else begin
            kind      = consul_pkg::PK_CHAR;
            next_code = print_char[6:0];    // Bit 7 not sent
        end
    end

endmodule

//--- verilog/consul_sequencer.sv
module consul_sequencer #(
    parameter int unsigned SETTLE_CYCLES = 1,
    parameter int unsigned SHIFT_CYCLES  = 11
) (
    input  logic                        Clk,
    input  logic                        Rst_n,

    // Host handshake
    input  logic                        print_req,
    input  logic                        key_req,
    output logic [7:0]                  key_char,
    output logic                        io_ack,

    // Line interface and encoder
    input  consul_pkg::consul_status_t  status,
    input  logic                        key_valid,
    input  logic [6:0]                  next_code,
    input  consul_pkg::print_kind_e     kind,
    output consul_pkg::consul_command_t command_next
);

    localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);
    localparam int SHIFT_W  = $clog2(SHIFT_CYCLES + 1);

    consul_pkg::consul_state_e state;
    consul_pkg::print_kind_e   kind_q;

    logic [SETTLE_W-1:0] settle_cnt;
    logic [SHIFT_W-1:0]  shift_cnt;
    logic                moving_seen;   // CR has started the carriage
    logic                sync_q;
    logic                kb_block_q;
    logic [6:0]          code_q;

    logic idle_free;
    logic accept_key;
    logic accept_print;

    // No new request until the previous acknowledge is cleared
    assign idle_free    = (state == consul_pkg::IDLE) && !io_ack;
    assign accept_key   = idle_free && key_req;
    assign accept_print = idle_free && print_req && !key_req
                          && !status.is_moving && !status.block_print;

    assign command_next.kb_block = kb_block_q;
    assign command_next.set_tab  = 1'b0;
    assign command_next.sync     = sync_q;
    assign command_next.code     = code_q;

    // Shift hold timer, runs from the acceptance edge
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            shift_cnt <= '0;
        end else if (accept_print) begin
            shift_cnt <= SHIFT_W'(SHIFT_CYCLES - 1);
        end else if (shift_cnt != '0) begin
            shift_cnt <= shift_cnt - SHIFT_W'(1);
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state       <= consul_pkg::IDLE;
            kind_q      <= consul_pkg::PK_CHAR;
            settle_cnt  <= '0;
            moving_seen <= 1'b0;
            sync_q      <= 1'b0;
            kb_block_q  <= 1'b1;
            code_q      <= '0;
            key_char    <= '0;
            io_ack      <= 1'b0;
        end else begin
            case (state)
                consul_pkg::IDLE: begin
                    if (io_ack && !print_req && !key_req) begin
                        io_ack <= 1'b0;
                    end
                    if (accept_key) begin
                        kb_block_q <= 1'b0;     // Release keyboard
                        state      <= consul_pkg::WAIT_KEY;
                    end else if (accept_print) begin
                        code_q      <= next_code;
                        kind_q      <= kind;
                        settle_cnt  <= SETTLE_W'(SETTLE_CYCLES - 1);
                        moving_seen <= 1'b0;
                        state       <= consul_pkg::SET_CODE;
                    end
                end
                consul_pkg::WAIT_KEY: begin
                    if (key_valid) begin
                        key_char   <= {status.top_symbol_correction, status.key_code[6:0]};
                        io_ack     <= 1'b1;
                        kb_block_q <= 1'b1;
                        state      <= consul_pkg::IDLE;
                    end
                end
                consul_pkg::SET_CODE: begin
                    // Code relays settle before sync
                    if (settle_cnt == '0) begin
                        state <= consul_pkg::SET_SYNC;
                    end else begin
                        settle_cnt <= settle_cnt - SETTLE_W'(1);
                    end
                end
                consul_pkg::SET_SYNC: begin
                    sync_q <= 1'b1;
                    if (kind_q == consul_pkg::PK_SHIFT) begin
                        state <= consul_pkg::WAIT_SHIFT;
                    end else begin
                        state <= consul_pkg::WAIT_PRINT;
                    end
                end
                consul_pkg::WAIT_SHIFT: begin
                    if (shift_cnt == '0) begin
                        sync_q <= 1'b0;
                        state  <= consul_pkg::IDLE;     // Character follows on next pass
                    end
                end
                consul_pkg::WAIT_PRINT: begin
                    if (kind_q == consul_pkg::PK_CR) begin
                        if (status.is_moving) begin
                            moving_seen <= 1'b1;
                        end
                        if (moving_seen && !status.is_moving) begin
                            sync_q <= 1'b0;
                            state  <= consul_pkg::IDLE;
                        end
                    end else if (status.co_acq) begin
                        sync_q <= 1'b0;
                        io_ack <= 1'b1;
                        state  <= consul_pkg::IDLE;
                    end
                end
                default: begin
                    state <= consul_pkg::IDLE;
                end
            endcase
        end
    end

    a_sync_state: assert property (@(posedge Clk) disable iff (!Rst_n)
        sync_q |-> !(state inside {consul_pkg::IDLE, consul_pkg::WAIT_KEY}));

    a_ack_sync: assert property (@(posedge Clk) disable iff (!Rst_n)
        !(io_ack && sync_q));

    a_state_legal: assert property (@(posedge Clk) disable iff (!Rst_n)
        state inside {consul_pkg::IDLE, consul_pkg::WAIT_KEY, consul_pkg::SET_CODE,
                      consul_pkg::SET_SYNC, consul_pkg::WAIT_PRINT, consul_pkg::WAIT_SHIFT});

    a_kb_block: assert property (@(posedge Clk) disable iff (!Rst_n)
        !kb_block_q |-> (state == consul_pkg::WAIT_KEY));

endmodule

//--- verilog/consul_top.sv
module consul_top #(
    parameter int unsigned SETTLE_CYCLES = 1,
    parameter int unsigned SHIFT_CYCLES  = 11
) (
    input  logic                        Clk,
    input  logic                        Rst_n,

    input  logic                        print_req,
    input  logic [7:0]                  print_char,
    input  logic                        key_req,
    output logic [7:0]                  key_char,
    output logic                        io_ack,

    input  consul_pkg::consul_status_t  status_lines,
    output consul_pkg::consul_command_t command_lines
);

    consul_pkg::consul_status_t  status;
    consul_pkg::consul_command_t command_next;
    consul_pkg::print_kind_e     kind;
    logic                        key_valid;
    logic [6:0]                  next_code;

    consul_line_interface u_line (
        .Clk           (Clk),
        .Rst_n         (Rst_n),
        .status_lines  (status_lines),
        .command_lines (command_lines),
        .command_next  (command_next),
        .status        (status),
        .key_valid     (key_valid)
    );

    consul_print_encoder u_encoder (
        .print_char (print_char),
        .status     (status),
        .next_code  (next_code),
        .kind       (kind)
    );

    consul_sequencer #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .SHIFT_CYCLES  (SHIFT_CYCLES)
    ) u_seq (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .print_req    (print_req),
        .key_req      (key_req),
        .key_char     (key_char),
        .io_ack       (io_ack),
        .status       (status),
        .key_valid    (key_valid),
        .next_code    (next_code),
        .kind         (kind),
        .command_next (command_next)
    );

endmodule

//--- verif/consul_machine_model.sv
module consul_machine_model (
    input  logic                        Clk,
    input  logic                        Rst_n,
    input  consul_pkg::consul_command_t command_lines,
    output consul_pkg::consul_status_t  status_lines
);

    logic sync_prev;
    int   move_cnt;     // Cycles left for carriage travel
    int   ack_cnt;      // Cycles left until print acknowledge

    initial status_lines = '0;

    always @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            status_lines <= '0;
            sync_prev    <= 1'b0;
            move_cnt     <= 0;
            ack_cnt      <= 0;
        end else begin
            sync_prev           <= command_lines.sync;
            status_lines.co_acq <= 1'b0;
            if (move_cnt == 1) begin
                status_lines.is_moving <= 1'b0;
            end
            if (move_cnt > 0) begin
                move_cnt <= move_cnt - 1;
            end
            if (ack_cnt == 1) begin
                status_lines.co_acq <= 1'b1;
            end
            if (ack_cnt > 0) begin
                ack_cnt <= ack_cnt - 1;
            end
            if (command_lines.sync && !sync_prev) begin
                if (command_lines.code[6:1] == consul_pkg::SHIFT_CODE_BASE) begin
                    status_lines.high_reg <= command_lines.code[0];
                end else if (command_lines.code == consul_pkg::CODE_CR) begin
                    status_lines.is_moving <= 1'b1;
                    status_lines.need_nl   <= 1'b0;
                    move_cnt               <= $urandom_range(10, 3);
                end else begin
                    ack_cnt <= $urandom_range(6, 1);
                end
            end
        end
    end

    task automatic set_need_nl(input logic value);
        status_lines.need_nl <= value;
    endtask

    task automatic set_block(input logic value);
        status_lines.block_print <= value;
    endtask

    task automatic set_key(input logic top, input logic [7:0] code);
        status_lines.top_symbol_correction <= top;
        status_lines.key_code              <= code;
        status_lines.cin_ready             <= code[7];
    endtask

endmodule

//--- verif/tb_consul.sv
module tb_consul;

    localparam int unsigned SETTLE_CYCLES = 2;
    localparam int unsigned SHIFT_CYCLES  = 11;
    localparam int unsigned SHIFT_HOLD    = SHIFT_CYCLES - SETTLE_CYCLES - 1;
    localparam int          MAX_CYCLES    = 3000;  // 6 tests of at most 500 cycles
    localparam int          ACK_LIMIT     = 200;

    logic                        Clk = 1'b0;
    logic                        Rst_n;
    logic                        print_req;
    logic [7:0]                  print_char;
    logic                        key_req;
    logic [7:0]                  key_char;
    logic                        io_ack;
    consul_pkg::consul_status_t  status_lines;
    consul_pkg::consul_command_t command_lines;

    logic [6:0] exp_code;     // Code due on the next sync rise
    logic [7:0] exp_key;
    logic       key_good;     // A valid key code is on the lines
    int         cycle      = 0;
    int         errors     = 0;
    int         pass_count = 0;
    int         fail_count = 0;

    always #2 Clk = ~Clk;

    consul_top #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .SHIFT_CYCLES  (SHIFT_CYCLES)
    ) UUT (
        .Clk           (Clk),
        .Rst_n         (Rst_n),
        .print_req     (print_req),
        .print_char    (print_char),
        .key_req       (key_req),
        .key_char      (key_char),
        .io_ack        (io_ack),
        .status_lines  (status_lines),
        .command_lines (command_lines)
    );

    consul_machine_model model (
        .Clk           (Clk),
        .Rst_n         (Rst_n),
        .command_lines (command_lines),
        .status_lines  (status_lines)
    );

    always @(posedge Clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("Error %0t: %s", $time, msg);
    endtask

    a_reset: assert property (@(posedge Clk) (cycle >= 1 && (!Rst_n || $past(!Rst_n)))
        |-> (!command_lines.sync && !command_lines.set_tab && command_lines.kb_block
             && !io_ack && key_char == 8'h00))
        else flag_error("outputs not at their reset values");

    a_set_tab: assert property (@(posedge Clk) disable iff (!Rst_n) !command_lines.set_tab)
        else flag_error("set_tab driven high");

    a_sync_code: assert property (@(posedge Clk) disable iff (!Rst_n)
        $rose(command_lines.sync) |-> command_lines.code == exp_code)
        else flag_error($sformatf("sync code %h, expected %h",
                                  $sampled(command_lines.code), $sampled(exp_code)));

    a_ack_after_acq: assert property (@(posedge Clk) disable iff (!Rst_n)
        $rose(io_ack) && print_req |-> $past(status_lines.co_acq, 2))
        else flag_error("print io_ack not two cycles after co_acq");

    a_shift_hold: assert property (@(posedge Clk) disable iff (!Rst_n)
        $rose(command_lines.sync) && command_lines.code[6:1] == consul_pkg::SHIFT_CODE_BASE
        |-> command_lines.sync [*SHIFT_HOLD] ##1 !command_lines.sync)
        else flag_error($sformatf("shift sync not held for %0d cycles", SHIFT_HOLD));

    a_extra_no_ack: assert property (@(posedge Clk) disable iff (!Rst_n)
        command_lines.sync && (command_lines.code == consul_pkg::CODE_CR
            || command_lines.code[6:1] == consul_pkg::SHIFT_CODE_BASE) |-> !io_ack)
        else flag_error("io_ack during a carriage return or case shift");

    a_cr_moving: assert property (@(posedge Clk) disable iff (!Rst_n)
        status_lines.is_moving
        |-> command_lines.sync && command_lines.code == consul_pkg::CODE_CR)
        else flag_error("sync with CR code not held while carriage moves");

    a_block_hold: assert property (@(posedge Clk) disable iff (!Rst_n)
        status_lines.block_print |-> !command_lines.sync && !io_ack)
        else flag_error("sync or io_ack while block_print is high");

    a_kb_release: assert property (@(posedge Clk) disable iff (!Rst_n)
        $rose(key_req) |-> ##2 !command_lines.kb_block)
        else flag_error("kb_block not released after key_req");

    a_bad_key: assert property (@(posedge Clk) disable iff (!Rst_n)
        key_req && !key_good |-> !io_ack)
        else flag_error("io_ack for an invalid key code");

    a_key_ack: assert property (@(posedge Clk) disable iff (!Rst_n)
        $rose(io_ack) && key_req |-> key_char == exp_key ##1 command_lines.kb_block)
        else flag_error($sformatf("key read gave %h, expected %h, or kb_block stayed low",
                                  $sampled(key_char), $sampled(exp_key)));

    function automatic logic [7:0] pick_char(input logic upper);
        logic [7:0] ch;
        ch    = 8'($urandom);
        ch[6] = 1'b1;       // Keeps clear of the CR and shift codes
        ch[5] = upper;
        return ch;
    endfunction

    function automatic logic [6:0] with_parity(input logic odd);
        logic [6:0] c;
        c = 7'($urandom);
        if ((^c) != odd) begin
            c[0] = ~c[0];
        end
        return c;
    endfunction

    task automatic wait_ack_clear();
        @(posedge Clk);
        while (io_ack) begin
            @(posedge Clk);
        end
    endtask

    task automatic print_one(input logic [7:0] ch, input logic [6:0] first_code);
        logic prev_sync;
        int   waited;
        prev_sync = 1'b0;
        waited    = 0;
        exp_code   <= first_code;
        print_char <= ch;
        print_req  <= 1'b1;
        @(posedge Clk);
        while (!io_ack && waited < ACK_LIMIT) begin
            if (command_lines.sync && !prev_sync) begin
                exp_code <= ch[6:0];    // Any later sync carries the character
            end
            prev_sync = command_lines.sync;
            waited++;
            @(posedge Clk);
        end
        if (!io_ack) begin
            errors++;
            $display("No io_ack within %0d cycles for the print of %h", ACK_LIMIT, ch);
        end
        print_req <= 1'b0;
        wait_ack_clear();
    endtask

    task automatic read_key(input logic top);
        logic [6:0] code;
        int         waited;
        waited = 0;
        key_good <= 1'b0;
        key_req  <= 1'b1;
        repeat (6) @(posedge Clk);
        model.set_key(top, {1'b1, with_parity(1'b0)});     // Strobe, even parity
        repeat (6) @(posedge Clk);
        model.set_key(top, {1'b0, with_parity(1'b1)});     // No strobe
        repeat (6) @(posedge Clk);
        code = with_parity(1'b1);
        exp_key  <= {top, code};
        key_good <= 1'b1;
        model.set_key(top, {1'b1, code});
        @(posedge Clk);
        while (!io_ack && waited < ACK_LIMIT) begin
            waited++;
            @(posedge Clk);
        end
        if (!io_ack) begin
            errors++;
            $display("No io_ack within %0d cycles for a valid key code", ACK_LIMIT);
        end
        key_req  <= 1'b0;
        key_good <= 1'b0;
        model.set_key(1'b0, 8'h00);
        wait_ack_clear();
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("Test %s: pass", name);
        end else begin
            fail_count++;
            $display("Test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        logic [7:0] ch;
        int         mark;
        void'($urandom(32'hfcc7));
        Rst_n      = 1'b0;
        print_req  = 1'b0;
        print_char = 8'h00;
        key_req    = 1'b0;
        exp_code   = '0;
        exp_key    = '0;
        key_good   = 1'b0;
        mark       = 0;
        repeat (4) @(posedge Clk);
        Rst_n <= 1'b1;
        repeat (2) @(posedge Clk);
        end_test("reset", mark);

        mark = errors;
        repeat (20) begin
            ch = pick_char(status_lines.high_reg);
            print_one(ch, ch[6:0]);
        end
        end_test("plain print", mark);

        mark = errors;
        repeat (4) begin
            ch = pick_char(~status_lines.high_reg);
            print_one(ch, {consul_pkg::SHIFT_CODE_BASE, ch[5]});
        end
        end_test("case shift", mark);

        mark = errors;
        repeat (2) begin
            model.set_need_nl(1'b1);
            repeat (2) @(posedge Clk);
            ch = pick_char(status_lines.high_reg);
            print_one(ch, consul_pkg::CODE_CR);
        end
        end_test("new line", mark);

        mark = errors;
        model.set_block(1'b1);
        repeat (2) @(posedge Clk);
        ch = pick_char(status_lines.high_reg);
        fork
            print_one(ch, ch[6:0]);
            begin
                repeat (30) @(posedge Clk);
                model.set_block(1'b0);
            end
        join
        end_test("back-pressure", mark);

        mark = errors;
        repeat (3) begin
            read_key(1'($urandom));
        end
        end_test("key read", mark);

        repeat (4) @(posedge Clk);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/consul_pkg.sv
verilog/consul_line_interface.sv
verilog/consul_print_encoder.sv
verilog/consul_sequencer.sv
verilog/consul_top.sv
verif/consul_machine_model.sv
verif/tb_consul.sv
